// ==== common/lz77_settings.svh ====
`ifndef LZ77_SETTINGS_SVH
`define LZ77_SETTINGS_SVH

// ----------------------------------------------------------------------
// window and match geometry
// ----------------------------------------------------------------------

// history depth in bytes, also the largest distance
`define LZ77_WIN_SIZE 32

// longest match, equal to the lookahead depth
`define LZ77_LEN_MAX 16

// shorter matches go out as literals
`define LZ77_LEN_MIN 3

// ----------------------------------------------------------------------
// data widths
// ----------------------------------------------------------------------

// symbol width
`define LZ77_BYTE_W 8

// block byte counter width
`define LZ77_CNT_W 16

`endif

// ==== common/lz77_cfg_pkg.sv ====
`default_nettype none

`include "lz77_settings.svh"

package lz77_cfg_pkg;

  // ----------------------------------------------------------------------
  // scalar widths used across the core
  // ----------------------------------------------------------------------

  // one symbol
  typedef logic [`LZ77_BYTE_W-1:0] byte_t;

  // match length, 0 .. LZ77_LEN_MAX
  typedef logic [$clog2(`LZ77_LEN_MAX+1)-1:0] len_t;

  // distance, 0 .. LZ77_WIN_SIZE (0 only on literals)
  typedef logic [$clog2(`LZ77_WIN_SIZE+1)-1:0] dst_t;

  // number of valid history bytes
  typedef logic [$clog2(`LZ77_WIN_SIZE+1)-1:0] fill_t;

  // bytes in a block
  typedef logic [`LZ77_CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

// ==== common/lz77_stream_pkg.sv ====
`default_nettype none

`include "lz77_settings.svh"

package lz77_stream_pkg;

  import lz77_cfg_pkg::*;

  // ----------------------------------------------------------------------
  // records passed between the pipeline stages
  // ----------------------------------------------------------------------

  // one compressed token
  // literal: len = 1, dst = 0
  typedef struct packed {
    logic  lit;
    byte_t lit_byte;
    len_t  len;
    dst_t  dst;
  } token_t;

  // window state handed to the search
  // win[0] is the most recent history byte, look[0] the next one to encode
  typedef struct packed {
    byte_t [`LZ77_WIN_SIZE-1:0] win;
    byte_t [`LZ77_LEN_MAX-1:0]  look;
    fill_t                      fill;
    len_t                       look_cnt;
  } snapshot_t;

  // ----------------------------------------------------------------------
  // search FSM
  // ----------------------------------------------------------------------

  typedef enum logic [1:0] {
    S_IDLE,
    S_SEARCH,
    S_HOLD
  } search_state_t;

endpackage

`default_nettype wire

// ==== lz77_window/lz77_window_buf.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lz77_settings.svh"

module lz77_window_buf
  import lz77_cfg_pkg::*;
  import lz77_stream_pkg::*;
(
  input  wire       clk,
  input  wire       rstn,
  // block control
  input  wire       start_i,
  input  cnt_t      total_len_i,
  // byte intake
  input  wire       in_valid_i,
  input  byte_t     in_data_i,
  output logic      in_ready_o,
  // snapshot to search
  output logic      snap_valid_o,
  output snapshot_t snap_o,
  input  wire       snap_ready_i,
  // bytes covered by the last token
  input  wire       consume_valid_i,
  input  len_t      consume_len_i
);

  byte_t [`LZ77_WIN_SIZE-1:0] win_r;
  byte_t [`LZ77_WIN_SIZE-1:0] win_nx;
  byte_t [`LZ77_LEN_MAX-1:0]  look_r;
  byte_t [`LZ77_LEN_MAX-1:0]  look_nx;

  len_t  look_cnt_r;
  len_t  look_cnt_nx;
  fill_t fill_r;
  fill_t fill_nx;
  cnt_t  rx_left_r;
  logic  snap_taken_r;
  logic  in_fire;

  // ----------------------------------------------------------------------
  // handshakes
  // ----------------------------------------------------------------------

  assign in_ready_o = (rx_left_r != '0) && (look_cnt_r != len_t'(`LZ77_LEN_MAX));
  assign in_fire    = in_valid_i && in_ready_o;

  // full lookahead, or the tail of the block once every byte is in
  assign snap_valid_o = !snap_taken_r && (look_cnt_r != '0) &&
                        ((look_cnt_r == len_t'(`LZ77_LEN_MAX)) || (rx_left_r == '0));

  always_comb begin
    snap_o.win      = win_r;
    snap_o.look     = look_r;
    snap_o.fill     = fill_r;
    snap_o.look_cnt = look_cnt_r;
  end

  // ----------------------------------------------------------------------
  // shift on consumption, append on intake
  // ----------------------------------------------------------------------

  always_comb begin
    int n;
    int wr;
    int fill_sum;
    n = consume_valid_i ? int'(consume_len_i) : 0;

    // consumed bytes enter history newest first
    for (int i = 0; i < `LZ77_WIN_SIZE; i++) begin
      if (i < n) begin
        win_nx[i] = look_r[n-1-i];
      end else begin
        win_nx[i] = win_r[i-n];
      end
    end

    look_nx = look_r;
    for (int i = 0; i < `LZ77_LEN_MAX; i++) begin
      if (i + n < `LZ77_LEN_MAX) begin
        look_nx[i] = look_r[i+n];
      end
    end

    // new byte lands behind whatever is left after the shift
    wr = int'(look_cnt_r) - n;
    if (in_fire) begin
      look_nx[wr] = in_data_i;
    end
    look_cnt_nx = len_t'(wr + (in_fire ? 1 : 0));

    fill_sum = int'(fill_r) + n;
    if (fill_sum > `LZ77_WIN_SIZE) begin
      fill_nx = fill_t'(`LZ77_WIN_SIZE);
    end else begin
      fill_nx = fill_t'(fill_sum);
    end
  end

  // data registers
  always_ff @(posedge clk) begin
    win_r  <= win_nx;
    look_r <= look_nx;
  end

  // ----------------------------------------------------------------------
  // counters
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      look_cnt_r   <= '0;
      fill_r       <= '0;
      rx_left_r    <= '0;
      snap_taken_r <= 1'b0;
    end else begin
      if (start_i) begin
        look_cnt_r   <= '0;
        fill_r       <= '0;
        rx_left_r    <= total_len_i;
        snap_taken_r <= 1'b0;
      end else begin
        look_cnt_r <= look_cnt_nx;
        fill_r     <= fill_nx;
        if (in_fire) begin
          rx_left_r <= rx_left_r - 1'b1;
        end
        // hold off until the search returns its token
        if (consume_valid_i) begin
          snap_taken_r <= 1'b0;
        end else if (snap_valid_o && snap_ready_i) begin
          snap_taken_r <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== lz77_search/lz77_match_search.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lz77_settings.svh"

module lz77_match_search
  import lz77_cfg_pkg::*;
  import lz77_stream_pkg::*;
(
  input  wire       clk,
  input  wire       rstn,
  // snapshot from window
  input  wire       snap_valid_i,
  input  snapshot_t snap_i,
  output logic      snap_ready_o,
  // shift request back to window
  output logic      consume_valid_o,
  output len_t      consume_len_o,
  // token to output stage
  output logic      tokr_valid_o,
  output token_t    tokr_o,
  input  wire       tokr_ready_i
);

  search_state_t state_r;

  snapshot_t snap_r;
  len_t      col_r;
  len_t      best_len_r;
  dst_t      best_dst_r;
  token_t    tok_r;

  logic [`LZ77_WIN_SIZE-1:0] mask_r;
  logic [`LZ77_WIN_SIZE-1:0] mask_nx;
  logic [`LZ77_WIN_SIZE-1:0] load_mask;

  logic   last_col;
  len_t   len_fin;
  dst_t   dst_fin;
  token_t tok_nx;

  // nearest candidate, bit j stands for distance j+1
  function automatic dst_t lowest_dst(input logic [`LZ77_WIN_SIZE-1:0] m);
    dst_t d;
    d = '0;
    for (int j = `LZ77_WIN_SIZE-1; j >= 0; j--) begin
      if (m[j]) begin
        d = dst_t'(j + 1);
      end
    end
    return d;
  endfunction

  // ----------------------------------------------------------------------
  // candidate mask
  // ----------------------------------------------------------------------

  // every distance up to the history fill
  always_comb begin
    for (int j = 0; j < `LZ77_WIN_SIZE; j++) begin
      load_mask[j] = (j < int'(snap_i.fill));
    end
  end

  // one column per cycle
  // the source runs from history into the lookahead when the match overlaps
  always_comb begin
    byte_t cur;
    byte_t src;
    cur = snap_r.look[col_r];
    for (int j = 0; j < `LZ77_WIN_SIZE; j++) begin
      if (int'(col_r) <= j) begin
        src = snap_r.win[j - int'(col_r)];
      end else begin
        src = snap_r.look[int'(col_r) - j - 1];
      end
      mask_nx[j] = mask_r[j] && (cur == src);
    end
  end

  // ----------------------------------------------------------------------
  // best match and token
  // ----------------------------------------------------------------------

  assign last_col = (mask_nx == '0) || (int'(col_r) + 1 >= int'(snap_r.look_cnt));
  assign len_fin  = (mask_nx != '0) ? len_t'(int'(col_r) + 1) : best_len_r;
  assign dst_fin  = (mask_nx != '0) ? lowest_dst(mask_nx) : best_dst_r;

  always_comb begin
    if (len_fin < len_t'(`LZ77_LEN_MIN)) begin
      tok_nx.lit      = 1'b1;
      tok_nx.lit_byte = snap_r.look[0];
      tok_nx.len      = len_t'(1);
      tok_nx.dst      = '0;
    end else begin
      tok_nx.lit      = 1'b0;
      tok_nx.lit_byte = '0;
      tok_nx.len      = len_fin;
      tok_nx.dst      = dst_fin;
    end
  end

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r <= S_IDLE;
      col_r   <= '0;
      mask_r  <= '0;
    end else begin
      case (state_r)
        S_IDLE: begin
          if (snap_valid_i) begin
            col_r   <= '0;
            mask_r  <= load_mask;
            state_r <= S_SEARCH;
          end
        end
        S_SEARCH: begin
          col_r  <= col_r + 1'b1;
          mask_r <= mask_nx;
          if (last_col) begin
            state_r <= S_HOLD;
          end
        end
        S_HOLD: begin
          if (tokr_ready_i) begin
            state_r <= S_IDLE;
          end
        end
        default: state_r <= S_IDLE;
      endcase
    end
  end

  // snapshot copy and running best
  always_ff @(posedge clk) begin
    if (state_r == S_IDLE && snap_valid_i) begin
      snap_r     <= snap_i;
      best_len_r <= '0;
      best_dst_r <= '0;
    end else if (state_r == S_SEARCH) begin
      best_len_r <= len_fin;
      best_dst_r <= dst_fin;
      if (last_col) begin
        tok_r <= tok_nx;
      end
    end
  end

  assign snap_ready_o    = (state_r == S_IDLE);
  assign tokr_valid_o    = (state_r == S_HOLD);
  assign tokr_o          = tok_r;
  assign consume_valid_o = tokr_valid_o && tokr_ready_i;
  assign consume_len_o   = tok_r.len;

endmodule

`default_nettype wire

// ==== hdl/lz77_token_out.sv ====
`timescale 1ns/10ps
`default_nettype none

module lz77_token_out
  import lz77_cfg_pkg::*;
  import lz77_stream_pkg::*;
(
  input  wire    clk,
  input  wire    rstn,
  input  wire    start_i,
  input  cnt_t   total_len_i,
  // from search
  input  wire    tokr_valid_i,
  input  token_t tokr_i,
  output logic   tokr_ready_o,
  // token port
  output logic   tok_valid_o,
  output token_t tok_o,
  input  wire    tok_ready_i,
  output logic   done_o
);

  logic active_r;
  cnt_t sent_r;
  cnt_t sent_nx;
  cnt_t total_r;
  logic in_fire;
  logic out_fire;
  logic done_w;

  // free slot, or the held token leaves this cycle
  assign tokr_ready_o = !tok_valid_o || tok_ready_i;
  assign in_fire      = tokr_valid_i && tokr_ready_o;
  assign out_fire     = tok_valid_o && tok_ready_i;

  assign sent_nx = sent_r + cnt_t'(tok_o.len);
  assign done_w  = active_r && out_fire && (sent_nx == total_r);

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (in_fire) begin
      tok_o <= tokr_i;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      tok_valid_o <= 1'b0;
      done_o      <= 1'b0;
      active_r    <= 1'b0;
      sent_r      <= '0;
      total_r     <= '0;
    end else begin
      if (in_fire) begin
        tok_valid_o <= 1'b1;
      end else if (out_fire) begin
        tok_valid_o <= 1'b0;
      end

      // byte accounting per block
      done_o <= done_w;
      if (start_i) begin
        active_r <= 1'b1;
        sent_r   <= '0;
        total_r  <= total_len_i;
      end else if (out_fire) begin
        sent_r <= sent_nx;
        if (done_w) begin
          active_r <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lz77_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module lz77_top
  import lz77_cfg_pkg::*;
  import lz77_stream_pkg::*;
(
  input  wire    clk,
  input  wire    rstn,
  // control
  input  wire    start_i,
  input  cnt_t   total_len_i,
  output logic   done_o,
  // byte input
  input  wire    in_valid_i,
  input  byte_t  in_data_i,
  output logic   in_ready_o,
  // token output
  output logic   tok_valid_o,
  output token_t tok_o,
  input  wire    tok_ready_i
);

  logic      snap_valid;
  snapshot_t snap;
  logic      snap_ready;
  logic      consume_valid;
  len_t      consume_len;
  logic      tokr_valid;
  token_t    tokr;
  logic      tokr_ready;

  // ----------------------------------------------------------------------
  // window, search, output
  // ----------------------------------------------------------------------

  lz77_window_buf u_window (
    .clk             (clk),
    .rstn            (rstn),
    .start_i         (start_i),
    .total_len_i     (total_len_i),
    .in_valid_i      (in_valid_i),
    .in_data_i       (in_data_i),
    .in_ready_o      (in_ready_o),
    .snap_valid_o    (snap_valid),
    .snap_o          (snap),
    .snap_ready_i    (snap_ready),
    .consume_valid_i (consume_valid),
    .consume_len_i   (consume_len)
  );

  lz77_match_search u_search (
    .clk             (clk),
    .rstn            (rstn),
    .snap_valid_i    (snap_valid),
    .snap_i          (snap),
    .snap_ready_o    (snap_ready),
    .consume_valid_o (consume_valid),
    .consume_len_o   (consume_len),
    .tokr_valid_o    (tokr_valid),
    .tokr_o          (tokr),
    .tokr_ready_i    (tokr_ready)
  );

  lz77_token_out u_token_out (
    .clk          (clk),
    .rstn         (rstn),
    .start_i      (start_i),
    .total_len_i  (total_len_i),
    .tokr_valid_i (tokr_valid),
    .tokr_i       (tokr),
    .tokr_ready_o (tokr_ready),
    .tok_valid_o  (tok_valid_o),
    .tok_o        (tok_o),
    .tok_ready_i  (tok_ready_i),
    .done_o       (done_o)
  );

endmodule

`default_nettype wire

// ==== verification/lz77_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module lz77_assert
  import lz77_cfg_pkg::*;
  import lz77_stream_pkg::*;
(
  input wire    clk,
  input wire    rstn,
  input wire    start_i,
  input wire    in_valid_i,
  input byte_t  in_data_i,
  input wire    in_ready_o,
  input wire    tok_valid_o,
  input token_t tok_o,
  input wire    tok_ready_i,
  input wire    done_o
);

  // failure count
  int   fail_cnt = 0;
  logic started_r;
  logic block_done_r;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      started_r    <= 1'b0;
      block_done_r <= 1'b0;
    end else begin
      if (start_i) begin
        started_r    <= 1'b1;
        block_done_r <= 1'b0;
      end else if (done_o) begin
        block_done_r <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // control and handshake rules
  // ----------------------------------------------------------------------

  // quiet until the first block opens
  a_idle: assert property (@(posedge clk) disable iff (!rstn)
    !started_r |-> !in_ready_o && !tok_valid_o && !done_o)
    else begin fail_cnt++; $error("outputs active before the first start"); end

  a_tok_hold: assert property (@(posedge clk) disable iff (!rstn)
    tok_valid_o && !tok_ready_i |=> tok_valid_o && $stable(tok_o))
    else begin fail_cnt++; $error("token changed or dropped under back-pressure"); end

  a_in_hold: assert property (@(posedge clk) disable iff (!rstn)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i))
    else begin fail_cnt++; $error("input byte changed or dropped before transfer"); end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
    done_o |=> !done_o)
    else begin fail_cnt++; $error("done_o held longer than one cycle"); end

  // nothing more until the next block
  a_after_done: assert property (@(posedge clk) disable iff (!rstn)
    block_done_r && !start_i |-> !tok_valid_o && !done_o)
    else begin fail_cnt++; $error("token or done after block completion"); end

endmodule

`default_nettype wire

// ==== verification/lz77_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lz77_settings.svh"

module lz77_tb
  import lz77_cfg_pkg::*;
  import lz77_stream_pkg::*;
();

  localparam int BYTE_TIMEOUT = 500;
  localparam int DONE_TIMEOUT = 20000;

  logic   clk;
  logic   rstn;
  logic   start_i;
  cnt_t   total_len_i;
  logic   done_o;
  logic   in_valid_i;
  byte_t  in_data_i;
  logic   in_ready_o;
  logic   tok_valid_o;
  token_t tok_o;
  logic   tok_ready_i;

  int     seed;
  int     errors;
  int     done_cnt;
  int     len_sum;
  byte_t  exp_q[$];
  byte_t  dec_q[$];
  token_t tok_log[$];

  lz77_top lz77_i (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .total_len_i (total_len_i),
    .done_o      (done_o),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .tok_valid_o (tok_valid_o),
    .tok_o       (tok_o),
    .tok_ready_i (tok_ready_i)
  );

  bind lz77_top lz77_assert u_assert (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .tok_valid_o (tok_valid_o),
    .tok_o       (tok_o),
    .tok_ready_i (tok_ready_i),
    .done_o      (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // random back-pressure on the token port
  initial begin
    @(posedge clk);
    forever begin
      @(negedge clk);
      tok_ready_i = ($random(seed) & 3) != 0;
    end
  end

  task automatic report_value(input string name, input int got, input int exp);
    errors++;
    $display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
  endtask

  task automatic report_range(input string name, input int got, input int lo, input int hi);
    errors++;
    $display("ERROR t=%0t %s: got %0d, expected %0d to %0d", $time, name, got, lo, hi);
  endtask

  task automatic report_text(input string msg);
    errors++;
    $display("t=%0t %s", $time, msg);
  endtask

  // ----------------------------------------------------------------------
  // shadow decoder
  // ----------------------------------------------------------------------

  task automatic push_byte(input byte_t b);
    int idx;
    idx = dec_q.size();
    if (idx >= exp_q.size()) begin
      report_text("decoder produced more bytes than the block holds");
    end else begin
      assert (b == exp_q[idx])
        else report_value($sformatf("decoded byte %0d", idx), b, exp_q[idx]);
    end
    dec_q.push_back(b);
  endtask

  always @(posedge clk) begin : decode
    int limit;
    int dst;
    if (rstn) begin
      if (done_o) begin
        done_cnt++;
        assert (len_sum == exp_q.size())
          else report_value("accepted length sum", len_sum, exp_q.size());
      end
      if (tok_valid_o && tok_ready_i) begin
        assert (done_cnt == 0) else report_text("token accepted after done_o");
        tok_log.push_back(tok_o);
        len_sum += int'(tok_o.len);
        dst = int'(tok_o.dst);
        limit = (dec_q.size() < `LZ77_WIN_SIZE) ? dec_q.size() : `LZ77_WIN_SIZE;
        if (tok_o.lit) begin
          assert (tok_o.len == len_t'(1)) else report_value("tok_o.len", tok_o.len, 1);
          push_byte(tok_o.lit_byte);
        end else begin
          assert (tok_o.len >= `LZ77_LEN_MIN && tok_o.len <= `LZ77_LEN_MAX)
            else report_range("tok_o.len", tok_o.len, `LZ77_LEN_MIN, `LZ77_LEN_MAX);
          assert (dst >= 1 && dst <= limit) else report_range("tok_o.dst", dst, 1, limit);
          // copy one byte at a time so overlapping matches work
          if (dst >= 1 && dst <= limit) begin
            for (int k = 0; k < int'(tok_o.len); k++) begin
              push_byte(dec_q[dec_q.size() - dst]);
            end
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  task automatic send_bytes();
    int t;
    for (int i = 0; i < exp_q.size(); i++) begin
      in_valid_i = 1'b1;
      in_data_i  = exp_q[i];
      t = 0;
      while (!in_ready_o && t < BYTE_TIMEOUT) begin
        @(negedge clk);
        t++;
      end
      if (!in_ready_o) begin
        report_text($sformatf("timeout, byte %0d was never accepted", i));
        in_valid_i = 1'b0;
        return;
      end
      // transfer on the coming rising edge
      @(negedge clk);
    end
    in_valid_i = 1'b0;
  endtask

  task automatic wait_done();
    int t;
    t = 0;
    while (done_cnt == 0 && t < DONE_TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (done_cnt == 0) begin
      report_text("timeout waiting for done_o");
    end
  endtask

  task automatic run_block();
    dec_q.delete();
    tok_log.delete();
    len_sum  = 0;
    done_cnt = 0;
    @(negedge clk);
    total_len_i = cnt_t'(exp_q.size());
    start_i     = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    send_bytes();
    wait_done();
    // quiet stretch to catch a second pulse or a stray token
    repeat (30) @(negedge clk);
    assert (done_cnt == 1) else report_value("done_o pulse count", done_cnt, 1);
    assert (dec_q.size() == exp_q.size())
      else report_value("decoded byte count", dec_q.size(), exp_q.size());
  endtask

  // longest then nearest gives literal plus three full-length pairs
  task automatic check_run_tokens();
    assert (tok_log.size() == 4) else report_value("run token count", tok_log.size(), 4);
    if (tok_log.size() == 4) begin
      assert (tok_log[0].lit) else report_value("run token 0 lit", tok_log[0].lit, 1);
      for (int i = 1; i < 4; i++) begin
        assert (!tok_log[i].lit && tok_log[i].len == len_t'(`LZ77_LEN_MAX))
          else report_value($sformatf("run token %0d len", i), tok_log[i].len, `LZ77_LEN_MAX);
        assert (tok_log[i].dst == dst_t'(1))
          else report_value($sformatf("run token %0d dst", i), tok_log[i].dst, 1);
      end
    end
  endtask

  initial begin
    seed        = 32'h32aa32dd;
    errors      = 0;
    done_cnt    = 0;
    len_sum     = 0;
    rstn        = 1'b0;
    start_i     = 1'b0;
    total_len_i = '0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    tok_ready_i = 1'b0;
    // 200 bytes over a four-symbol alphabet
    for (int i = 0; i < 200; i++) begin
      exp_q.push_back(byte_t'(8'h61 + ($random(seed) & 3)));
    end
    repeat (8) @(negedge clk);
    rstn = 1'b1;
    repeat (5) @(negedge clk);
    run_block();
    exp_q.delete();
    repeat (49) exp_q.push_back(8'h7a);
    run_block();
    check_run_tokens();
    $display("errors: %0d testbench, %0d bound assertions", errors, lz77_i.u_assert.fail_cnt);
    if (errors == 0 && lz77_i.u_assert.fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/lz77_cfg_pkg.sv
common/lz77_stream_pkg.sv
lz77_window/lz77_window_buf.sv
lz77_search/lz77_match_search.sv
hdl/lz77_token_out.sv
hdl/lz77_top.sv
verification/lz77_assert.sv
verification/lz77_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the LZ77 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module lz77_tb -f src.f -o lz77_sim

out=$(./obj_dir/lz77_sim +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -qx "=== PASS ==="
